//--- tb.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_stage_if.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core_top.sv
test/tb_clock_gen.sv
test/rv_core_assertions.sv
test/tb_rv_core.sv

//--- test/rv_core_input.txt
// first data word: number of instructions (hex)
// then per line: instruction, expected illegal, expected rd, expected value
16
123450B7 0 01 12345000
00001117 0 02 00001004
FFB00193 0 03 FFFFFFFB
00718213 0 04 00000002
0011A293 0 05 00000001
0011B313 0 06 00000000
4011D393 0 07 FFFFFFFD
0011D413 0 08 7FFFFFFD
403204B3 0 09 00000007
02118633 0 0C A4FA7000
021196B3 0 0D FFFFFFFF
0231A733 0 0E FFFFFFFB
0231B7B3 0 0F FFFFFFF6
00108013 0 00 12345001
00400833 0 10 00000002
00000463 1 00 00000000
0000A203 1 00 00000000
30009273 1 00 00000000
10500073 1 00 00000000
008268B3 0 11 7FFFFFFF
0072C933 0 12 FFFFFFFC
00000997 0 13 00000054

//--- test/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int MAX_TESTS  = 64;
    localparam int ACK_WAIT   = 4;
    localparam int DRAIN_WAIT = 8;

    typedef struct packed {
        int                    index;
        rv_core_pkg::xlen_t    instr;
        logic                  illegal;
        rv_core_pkg::reg_idx_t rd;
        rv_core_pkg::xlen_t    value;
    } retire_t;

    logic                  clock;
    logic                  reset;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    rv_core_pkg::xlen_t    wb_dat_w;
    logic                  wb_ack;
    logic                  retire_valid;
    rv_core_pkg::reg_idx_t retire_rd;
    rv_core_pkg::xlen_t    retire_value;
    logic                  retire_illegal;

    // count word followed by four words per instruction
    rv_core_pkg::xlen_t vectors [0:4*MAX_TESTS];
    retire_t            expect_q [$];

    int num_tests;
    int pass_count;
    int fail_count;
    int other_errors;
    int assert_failures;
    int cycle_count;
    int timeout_limit;
    int drain_cycles;

    tb_clock_gen u_tb_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    rv_core_top u_rv_core_top (
        .clock          (clock),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_dat_w       (wb_dat_w),
        .wb_ack         (wb_ack),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value),
        .retire_illegal (retire_illegal)
    );

    ////////////////////////////////////////////////////////////////////
    // wishbone write of one instruction
    ////////////////////////////////////////////////////////////////////

    task automatic issue(input int idx);
        retire_t exp;
        int      wait_cycles;
        exp.index   = idx;
        exp.instr   = vectors[1 + 4*idx];
        exp.illegal = vectors[2 + 4*idx][0];
        exp.rd      = vectors[3 + 4*idx][4:0];
        exp.value   = vectors[4 + 4*idx];
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = 1'b1;
        wb_dat_w    = exp.instr;
        expect_q.push_back(exp);
        wait_cycles = 0;
        @(negedge clock);
        while (wb_ack !== 1'b1 && wait_cycles < ACK_WAIT) begin
            wait_cycles++;
            @(negedge clock);
        end
        if (wb_ack !== 1'b1) begin
            $display("instruction %0d (%h) was never acknowledged", idx, exp.instr);
            other_errors++;
            void'(expect_q.pop_back());
        end
        // hold the request through the edge where ack is high
        @(negedge clock);
    endtask

    task automatic check_retire();
        retire_t exp;
        logic    ok;
        if (expect_q.size() == 0) begin
            $display("retire at %0t with no instruction outstanding", $time);
            other_errors++;
        end else begin
            exp = expect_q.pop_front();
            ok  = 1'b1;
            if (retire_illegal !== exp.illegal) begin
                $display("Error at %0t: retire_illegal expected %0b actual %0b",
                         $time, exp.illegal, retire_illegal);
                ok = 1'b0;
            end
            if (retire_rd !== exp.rd) begin
                $display("Error at %0t: retire_rd expected %0d actual %0d",
                         $time, exp.rd, retire_rd);
                ok = 1'b0;
            end
            if (retire_value !== exp.value) begin
                $display("Error at %0t: retire_value expected %h actual %h",
                         $time, exp.value, retire_value);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("test %0d instr %h: %s", exp.index, exp.instr,
                     ok ? "passed" : "failed");
        end
    endtask

    // retire monitor
    always @(negedge clock) begin
        if (reset === 1'b0 && retire_valid === 1'b1) begin
            check_retire();
        end
    end

    always @(posedge clock) begin
        if (reset === 1'b0) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("run stopped after %0d cycles without finishing", cycle_count);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_dat_w        = '0;
        pass_count      = 0;
        fail_count      = 0;
        other_errors    = 0;
        assert_failures = 0;
        cycle_count     = 0;
        $readmemh("test/rv_core_input.txt", vectors);
        num_tests     = int'(vectors[0]);
        timeout_limit = 6*num_tests + 50;
        while (reset !== 1'b0) begin
            @(negedge clock);
        end
        for (int i = 0; i < num_tests; i++) begin
            issue(i);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        drain_cycles = 0;
        while (expect_q.size() != 0 && drain_cycles < DRAIN_WAIT) begin
            @(negedge clock);
            drain_cycles++;
        end
        // a few idle cycles to catch stray retires
        repeat (2) @(negedge clock);
        if (expect_q.size() != 0) begin
            $display("%0d instructions never retired", expect_q.size());
            other_errors++;
        end
        assert_failures = u_rv_core_top.u_rv_core_assertions.failures;
        $display("%0d tests: %0d passed, %0d failed, %0d other errors, %0d assertion failures",
                 num_tests, pass_count, fail_count, other_errors, assert_failures);
        if (fail_count == 0 && other_errors == 0 && assert_failures == 0 &&
            pass_count == num_tests) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
    input logic                  clock,
    input logic                  reset,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input logic                  wb_ack,
    input logic                  retire_valid,
    input logic                  retire_illegal,
    input rv_core_pkg::reg_idx_t retire_rd
);

    logic request;
    int   failures = 0;

    // write request sampled while no ack is pending
    assign request = wb_cyc && wb_stb && wb_we && !wb_ack;

    ack_single_cycle: assert property (
        @(posedge clock) disable iff (reset) wb_ack |=> !wb_ack
    ) else begin
        $error("wb_ack held high for two cycles");
        failures++;
    end

    ack_after_request: assert property (
        @(posedge clock) disable iff (reset) request |=> wb_ack
    ) else begin
        $error("wb_ack missing one cycle after a request");
        failures++;
    end

    ack_has_request: assert property (
        @(posedge clock) disable iff (reset) wb_ack |-> $past(request)
    ) else begin
        $error("wb_ack without a request on the previous edge");
        failures++;
    end

    // retire port loads two edges after the sampling edge
    retire_latency: assert property (
        @(posedge clock) disable iff (reset) request |-> ##3 retire_valid
    ) else begin
        $error("retire_valid did not follow an accepted request");
        failures++;
    end

    illegal_rd_zero: assert property (
        @(posedge clock) disable iff (reset)
            (retire_valid && retire_illegal) |-> (retire_rd == '0)
    ) else begin
        $error("illegal retire with nonzero retire_rd");
        failures++;
    end

endmodule

bind rv_core_top rv_core_assertions u_rv_core_assertions (
    .clock          (clock),
    .reset          (reset),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_ack         (wb_ack),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd)
);

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                  clock,
    input  logic                  reset,

    // wishbone classic slave, instruction writes only
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  rv_core_pkg::xlen_t    wb_dat_w,
    output logic                  wb_ack,

    output logic                  retire_valid,
    output rv_core_pkg::reg_idx_t retire_rd,
    output rv_core_pkg::xlen_t    retire_value,
    output logic                  retire_illegal
);

    rv_core_pkg::reg_idx_t rs1_idx;
    rv_core_pkg::reg_idx_t rs2_idx;
    rv_core_pkg::xlen_t    rs1_data;
    rv_core_pkg::xlen_t    rs2_data;

    decode_exec_if u_decode_exec_if ();
    exec_result_if u_exec_result_if ();

    rv_decode u_rv_decode (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .to_exec  (u_decode_exec_if.decode),
        .fwd      (u_exec_result_if.forward)
    );

    rv_execute u_rv_execute (
        .clock       (clock),
        .reset       (reset),
        .from_decode (u_decode_exec_if.execute),
        .to_result   (u_exec_result_if.execute)
    );

    rv_result u_rv_result (
        .clock          (clock),
        .reset          (reset),
        .from_exec      (u_exec_result_if.result),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .retire_valid   (retire_valid),
        .retire_illegal (retire_illegal),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value)
    );

endmodule

`default_nettype wire

//--- rtl/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_result (
    input  logic                  clock,
    input  logic                  reset,
    exec_result_if.result         from_exec,
    input  rv_core_pkg::reg_idx_t rs1_idx,
    input  rv_core_pkg::reg_idx_t rs2_idx,
    output rv_core_pkg::xlen_t    rs1_data,
    output rv_core_pkg::xlen_t    rs2_data,
    output logic                  retire_valid,
    output logic                  retire_illegal,
    output rv_core_pkg::reg_idx_t retire_rd,
    output rv_core_pkg::xlen_t    retire_value
);

    rv_core_pkg::xlen_t regs [`RV_REG_COUNT];
    logic               rf_we;

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////

    // x0 is never written
    assign rf_we = from_exec.valid && from_exec.write_en && (from_exec.rd != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[from_exec.rd] <= from_exec.value;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    //////////////////////////////////////////////////////////////////////
    // retire port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= from_exec.valid;
        end
    end

    // illegal ops report a clean zero
    always_ff @(posedge clock) begin
        if (from_exec.valid) begin
            retire_illegal <= from_exec.illegal;
            retire_rd      <= from_exec.illegal ? '0 : from_exec.rd;
            retire_value   <= from_exec.illegal ? '0 : from_exec.value;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_execute (
    input logic            clock,
    input logic            reset,
    decode_exec_if.execute from_decode,
    exec_result_if.execute to_result
);

    rv_core_pkg::xlen_t            a;
    rv_core_pkg::xlen_t            b;
    logic [4:0]                    shamt;
    logic signed [`RV_XLEN:0]      mul_a;
    logic signed [`RV_XLEN:0]      mul_b;
    logic signed [2*`RV_XLEN+1:0]  product;
    rv_core_pkg::xlen_t            alu_out;

    assign a     = from_decode.opa;
    assign b     = from_decode.opb;
    assign shamt = b[4:0];

    // one 33x33 signed multiplier covers all four products
    assign mul_a = {(from_decode.alu_func == rv_core_pkg::ALU_MULH ||
                     from_decode.alu_func == rv_core_pkg::ALU_MULHSU) && a[`RV_XLEN-1], a};
    assign mul_b = {(from_decode.alu_func == rv_core_pkg::ALU_MULH) && b[`RV_XLEN-1], b};
    assign product = mul_a * mul_b;

    always_comb begin
        case (from_decode.alu_func)
            rv_core_pkg::ALU_SUB:    alu_out = a - b;
            rv_core_pkg::ALU_SLT:    alu_out = rv_core_pkg::xlen_t'($signed(a) < $signed(b));
            rv_core_pkg::ALU_SLTU:   alu_out = rv_core_pkg::xlen_t'(a < b);
            rv_core_pkg::ALU_AND:    alu_out = a & b;
            rv_core_pkg::ALU_OR:     alu_out = a | b;
            rv_core_pkg::ALU_XOR:    alu_out = a ^ b;
            rv_core_pkg::ALU_SLL:    alu_out = a << shamt;
            rv_core_pkg::ALU_SRL:    alu_out = a >> shamt;
            rv_core_pkg::ALU_SRA:    alu_out = $signed(a) >>> shamt;
            rv_core_pkg::ALU_MUL:    alu_out = product[`RV_XLEN-1:0];
            rv_core_pkg::ALU_MULH,
            rv_core_pkg::ALU_MULHSU,
            rv_core_pkg::ALU_MULHU:  alu_out = product[2*`RV_XLEN-1:`RV_XLEN];
            default:                 alu_out = a + b;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            to_result.valid <= 1'b0;
        end else begin
            to_result.valid <= from_decode.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (from_decode.valid) begin
            to_result.rd       <= from_decode.rd;
            to_result.value    <= alu_out;
            to_result.write_en <= from_decode.write_en;
            to_result.illegal  <= from_decode.illegal;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_decode (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  rv_core_pkg::xlen_t    wb_dat_w,
    output logic                  wb_ack,
    output rv_core_pkg::reg_idx_t rs1_idx,
    output rv_core_pkg::reg_idx_t rs2_idx,
    input  rv_core_pkg::xlen_t    rs1_data,
    input  rv_core_pkg::xlen_t    rs2_data,
    decode_exec_if.decode         to_exec,
    exec_result_if.forward        fwd
);

    logic                   accept;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv_core_pkg::alu_func_t base_func;
    rv_core_pkg::alu_func_t alu_func;
    rv_core_pkg::opa_sel_t  opa_sel;
    rv_core_pkg::opb_sel_t  opb_sel;
    logic                   write_en;
    logic                   illegal;
    rv_core_pkg::xlen_t     i_imm;
    rv_core_pkg::xlen_t     u_imm;
    rv_core_pkg::xlen_t     cur_pc;
    logic                   fwd_rs1;
    logic                   fwd_rs2;
    rv_core_pkg::xlen_t     rs1_val;
    rv_core_pkg::xlen_t     rs2_val;
    rv_core_pkg::xlen_t     opa;
    rv_core_pkg::xlen_t     opb;

    // write request, one per ack
    assign accept = wb_cyc && wb_stb && wb_we && !wb_ack;

    assign opcode  = wb_dat_w[6:0];
    assign funct3  = wb_dat_w[14:12];
    assign funct7  = wb_dat_w[31:25];
    assign rs1_idx = wb_dat_w[19:15];
    assign rs2_idx = wb_dat_w[24:20];

    assign i_imm = {{20{wb_dat_w[31]}}, wb_dat_w[31:20]};
    assign u_imm = {wb_dat_w[31:12], 12'b0};

    // next pc is one step past the last accepted instruction
    assign cur_pc = to_exec.pc + rv_core_pkg::xlen_t'(`RV_PC_STEP);

    //////////////////////////////////////////////////////////////////////
    // instruction match
    //////////////////////////////////////////////////////////////////////

    // funct3 alone picks the base alu op
    always_comb begin
        case (funct3)
            rv_core_pkg::F3_ADD:  base_func = rv_core_pkg::ALU_ADD;
            rv_core_pkg::F3_SLL:  base_func = rv_core_pkg::ALU_SLL;
            rv_core_pkg::F3_SLT:  base_func = rv_core_pkg::ALU_SLT;
            rv_core_pkg::F3_SLTU: base_func = rv_core_pkg::ALU_SLTU;
            rv_core_pkg::F3_XOR:  base_func = rv_core_pkg::ALU_XOR;
            rv_core_pkg::F3_SRL:  base_func = rv_core_pkg::ALU_SRL;
            rv_core_pkg::F3_OR:   base_func = rv_core_pkg::ALU_OR;
            default:              base_func = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        alu_func = base_func;
        opa_sel  = rv_core_pkg::OPA_IS_RS1;
        opb_sel  = rv_core_pkg::OPB_IS_RS2;
        write_en = 1'b1;
        illegal  = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                alu_func = rv_core_pkg::ALU_ADD;
                opa_sel  = rv_core_pkg::OPA_IS_ZERO;
                opb_sel  = rv_core_pkg::OPB_IS_U_IMM;
            end
            rv_core_pkg::OPC_AUIPC: begin
                alu_func = rv_core_pkg::ALU_ADD;
                opa_sel  = rv_core_pkg::OPA_IS_PC;
                opb_sel  = rv_core_pkg::OPB_IS_U_IMM;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                opb_sel = rv_core_pkg::OPB_IS_I_IMM;
                // shift immediates carry a funct7
                if (funct3 == rv_core_pkg::F3_SLL) begin
                    illegal = (funct7 != rv_core_pkg::F7_BASE);
                end else if (funct3 == rv_core_pkg::F3_SRL) begin
                    if (funct7 == rv_core_pkg::F7_ALT) begin
                        alu_func = rv_core_pkg::ALU_SRA;
                    end else if (funct7 != rv_core_pkg::F7_BASE) begin
                        illegal = 1'b1;
                    end
                end
            end
            rv_core_pkg::OPC_OP: begin
                if (funct7 == rv_core_pkg::F7_ALT && funct3 == rv_core_pkg::F3_ADD) begin
                    alu_func = rv_core_pkg::ALU_SUB;
                end else if (funct7 == rv_core_pkg::F7_ALT && funct3 == rv_core_pkg::F3_SRL) begin
                    alu_func = rv_core_pkg::ALU_SRA;
                end else if (funct7 == rv_core_pkg::F7_MULDIV && !funct3[2]) begin
                    case (funct3[1:0])
                        2'b00:   alu_func = rv_core_pkg::ALU_MUL;
                        2'b01:   alu_func = rv_core_pkg::ALU_MULH;
                        2'b10:   alu_func = rv_core_pkg::ALU_MULHSU;
                        default: alu_func = rv_core_pkg::ALU_MULHU;
                    endcase
                end else if (funct7 != rv_core_pkg::F7_BASE) begin
                    // div/rem and unknown encodings
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            write_en = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // operand select with bypass
    //////////////////////////////////////////////////////////////////////

    // the producer one stage ahead is the write landing this edge
    assign fwd_rs1 = fwd.valid && fwd.write_en && (fwd.rd != '0) && (fwd.rd == rs1_idx);
    assign fwd_rs2 = fwd.valid && fwd.write_en && (fwd.rd != '0) && (fwd.rd == rs2_idx);
    assign rs1_val = fwd_rs1 ? fwd.value : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd.value : rs2_data;

    always_comb begin
        case (opa_sel)
            rv_core_pkg::OPA_IS_PC:   opa = cur_pc;
            rv_core_pkg::OPA_IS_ZERO: opa = '0;
            default:                  opa = rs1_val;
        endcase
        case (opb_sel)
            rv_core_pkg::OPB_IS_I_IMM: opb = i_imm;
            rv_core_pkg::OPB_IS_U_IMM: opb = u_imm;
            default:                   opb = rs2_val;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            to_exec.valid <= 1'b0;
            to_exec.pc    <= rv_core_pkg::xlen_t'(`RV_PC_RESET - `RV_PC_STEP);
        end else begin
            wb_ack        <= accept;
            to_exec.valid <= accept;
            if (accept) begin
                to_exec.pc <= cur_pc;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            to_exec.alu_func <= alu_func;
            to_exec.opa      <= opa;
            to_exec.opb      <= opb;
            to_exec.rd       <= wb_dat_w[11:7];
            to_exec.write_en <= write_en;
            to_exec.illegal  <= illegal;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction with selected operands
interface decode_exec_if;
    logic                   valid;
    rv_core_pkg::alu_func_t alu_func;
    rv_core_pkg::xlen_t     opa;
    rv_core_pkg::xlen_t     opb;
    rv_core_pkg::reg_idx_t  rd;
    logic                   write_en;
    logic                   illegal;
    rv_core_pkg::xlen_t     pc;

    modport decode (
        output valid, alu_func, opa, opb, rd, write_en, illegal, pc
    );
    modport execute (
        input valid, alu_func, opa, opb, rd, write_en, illegal, pc
    );
endinterface

// alu result on its way to writeback
interface exec_result_if;
    logic                  valid;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::xlen_t    value;
    logic                  write_en;
    logic                  illegal;

    modport execute (output valid, rd, value, write_en, illegal);
    modport result (input valid, rd, value, write_en, illegal);

    // bypass tap for decode
    modport forward (input valid, rd, value, write_en);
endinterface

`default_nettype wire

//--- rtl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_U_IMM
    } opb_sel_t;

    //////////////////////////////////////////////////////////////////////
    // rv32 opcode and funct fields
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

//--- rtl/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath width
`define RV_XLEN 32

// register file size and index width
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// pc counter that stands in for fetch
`define RV_PC_RESET 0
`define RV_PC_STEP 4

`endif
